// ==== Makefile ====
TOP = tb_fetch_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_top.f -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f fetch_top.f

clean:
	rm -rf obj_dir

// ==== fetch_top.f ====
tinyfe_pkg.sv
inst_rom.sv
mem_arbiter.sv
fetch_unit.sv
load_port.sv
if_id.sv
fetch_top.sv
fetch_top_assertions.sv
tb_fetch_top.sv

// ==== fetch_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction front end top
// rom, arbiter, fetch unit, load port and if_id
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_top
    import tinyfe_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire hold_e                  hold_i,
    input  wire logic [InstAddrBus-1:0] jump_addr_i,
    input  wire logic [INT_BUS-1:0]     int_flag_i,
    input  wire logic                   ready_i,
    output logic                        valid_o,
    output logic      [InstBus-1:0]     inst_o,
    output logic      [InstAddrBus-1:0] inst_addr_o,
    output logic      [InstAddrBus-1:0] inst_addr_next_o,
    output logic      [INT_BUS-1:0]     int_flag_o,
    input  wire logic                   load_req_i,
    input  wire logic [InstAddrBus-1:0] load_addr_i,
    output logic                        load_ack_o,
    output logic      [InstBus-1:0]     load_data_o
);

    mem_req_t           fetch_req;   // fetch unit to arbiter
    mem_rsp_t           fetch_rsp;
    mem_req_t           load_req;    // load port to arbiter
    mem_rsp_t           load_rsp;
    logic               rom_en;
    logic [RomAw-1:0]   rom_addr;
    logic [InstBus-1:0] rom_data;
    fetch_item_t        item;        // buffered word to if_id
    logic               instr_req;
    logic               instr_ready;

    inst_rom u_rom (
        .clk_i,
        .rd_en_i  (rom_en),
        .rd_addr_i(rom_addr),
        .rd_data_o(rom_data)
    );

    mem_arbiter u_arb (
        .clk_i,
        .rst_ni,
        .fetch_req_i(fetch_req),
        .load_req_i (load_req),
        .fetch_rsp_o(fetch_rsp),
        .load_rsp_o (load_rsp),
        .rom_en_o   (rom_en),
        .rom_addr_o (rom_addr),
        .rom_data_i (rom_data)
    );

    fetch_unit u_fetch (
        .clk_i,
        .rst_ni,
        .hold_i,
        .jump_addr_i,
        .mem_req_o    (fetch_req),
        .mem_rsp_i    (fetch_rsp),
        .instr_req_i  (instr_req),
        .instr_ready_o(instr_ready),
        .item_o       (item)
    );

    load_port u_load (
        .clk_i,
        .rst_ni,
        .load_req_i,
        .load_addr_i,
        .load_ack_o,
        .load_data_o,
        .mem_req_o(load_req),
        .mem_rsp_i(load_rsp)
    );

    if_id u_if_id (
        .clk_i,
        .rst_ni,
        .ready_i,
        .item_i       (item),
        .hold_i,
        .int_flag_i,
        .int_flag_o,
        .inst_o,
        .inst_addr_o,
        .inst_addr_next_o,
        .instr_req_o  (instr_req),
        .instr_ready_i(instr_ready),
        .valid_o
    );

endmodule

`default_nettype wire

// ==== fetch_top_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end protocol checks
// four-phase rules on both arbiter ports and
// stable if_id outputs while decode stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_top_assertions
    import tinyfe_pkg::*;
(
    input wire logic                   clk_i,
    input wire logic                   rst_ni,
    input wire mem_req_t               fetch_req,
    input wire mem_rsp_t               fetch_rsp,
    input wire mem_req_t               load_req,
    input wire mem_rsp_t               load_rsp,
    input wire hold_e                  hold_i,
    input wire logic                   ready_i,
    input wire logic                   valid_o,
    input wire logic [InstBus-1:0]     inst_o,
    input wire logic [InstAddrBus-1:0] inst_addr_o,
    input wire logic [InstAddrBus-1:0] inst_addr_next_o,
    input wire logic [INT_BUS-1:0]     int_flag_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // ack only answers a live req
    a_fetch_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(fetch_rsp.ack) |-> fetch_req.req)
        else $error("fetch ack rose without req");
    a_load_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(load_rsp.ack) |-> load_req.req)
        else $error("load ack rose without req");

    // no req withdrawn before its ack
    a_fetch_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req.req && !fetch_rsp.ack |=> fetch_req.req)
        else $error("fetch req dropped before ack");
    a_load_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_req.req && !load_rsp.ack |=> load_req.req)
        else $error("load req dropped before ack");

    // stalled item holds unless flushed
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i && hold_i != PIPE_CLEAR
        |=> valid_o && $stable(inst_o) && $stable(inst_addr_o)
            && $stable(inst_addr_next_o) && $stable(int_flag_o))
        else $error("if_id outputs changed during stall");

endmodule

bind fetch_top fetch_top_assertions u_assertions (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_req       (fetch_req),
    .fetch_rsp       (fetch_rsp),
    .load_req        (load_req),
    .load_rsp        (load_rsp),
    .hold_i          (hold_i),
    .ready_i         (ready_i),
    .valid_o         (valid_o),
    .inst_o          (inst_o),
    .inst_addr_o     (inst_addr_o),
    .inst_addr_next_o(inst_addr_next_o),
    .int_flag_o      (int_flag_o)
);

`default_nettype wire

// ==== fetch_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch unit
// walks the pc, reads the rom over four-phase and
// keeps one word buffered for if_id
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_unit
    import tinyfe_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire hold_e                  hold_i,
    input  wire logic [InstAddrBus-1:0] jump_addr_i,   // redirect target
    output mem_req_t                    mem_req_o,
    input  wire mem_rsp_t               mem_rsp_i,
    input  wire logic                   instr_req_i,   // if_id can take a word
    output logic                        instr_ready_o, // buffer holds a word
    output fetch_item_t                 item_o
);

    logic [InstAddrBus-1:0] pc_q;
    logic [InstAddrBus-1:0] req_addr_q;  // byte address of read in flight
    logic [InstAddrBus-1:0] next_addr;
    logic                   req_q;
    logic                   stale_q;     // answer to be dropped
    logic                   buf_valid_q;
    fetch_item_t            buf_q;
    logic                   redirect;
    logic                   xfer;
    logic                   buf_free;
    logic                   accept;
    logic                   fill;
    logic                   issue;

    assign redirect  = (hold_i == PIPE_CLEAR);
    assign xfer      = instr_req_i & buf_valid_q;          // word leaves to if_id
    assign buf_free  = ~buf_valid_q | xfer | redirect;
    assign accept    = req_q & mem_rsp_i.ack & buf_free;   // take data, drop req
    assign fill      = accept & ~stale_q & ~redirect;
    assign issue     = ~req_q & ~mem_rsp_i.ack & (hold_i == HOLD_NONE);
    assign next_addr = req_addr_q + 32'd4;

    always_ff @(posedge clk_i) begin : fetch_ctrl
        if (!rst_ni) begin
            pc_q        <= '0;
            req_q       <= 1'b0;
            stale_q     <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            if (issue) req_q <= 1'b1;
            else if (accept) req_q <= 1'b0;

            if (redirect) stale_q <= req_q & ~accept;  // finish it, drop it
            else if (accept) stale_q <= 1'b0;

            if (redirect) pc_q <= jump_addr_i;
            else if (fill) pc_q <= next_addr;

            if (redirect) buf_valid_q <= 1'b0;
            else if (fill) buf_valid_q <= 1'b1;
            else if (xfer) buf_valid_q <= 1'b0;
        end
    end : fetch_ctrl

    always_ff @(posedge clk_i) begin : fetch_data
        if (issue) req_addr_q <= pc_q;  // stable for the whole handshake
        if (fill) begin
            buf_q <= '{inst: mem_rsp_i.data, inst_addr: req_addr_q, inst_addr_next: next_addr};
        end
    end : fetch_data

    assign mem_req_o     = '{req: req_q, addr: req_addr_q[RomAw+1:2]};
    assign instr_ready_o = buf_valid_q;
    assign item_o        = buf_q;

endmodule

`default_nettype wire

// ==== if_id.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch to decode pipeline register
// valid/ready to decode, flush to nop on clear,
// interrupt flags captured next to each instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module if_id
    import tinyfe_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   ready_i,          // decode takes item
    input  wire fetch_item_t            item_i,
    input  wire hold_e                  hold_i,
    input  wire logic [INT_BUS-1:0]     int_flag_i,       // peripheral irqs
    output logic      [INT_BUS-1:0]     int_flag_o,
    output logic      [InstBus-1:0]     inst_o,
    output logic      [InstAddrBus-1:0] inst_addr_o,
    output logic      [InstAddrBus-1:0] inst_addr_next_o,
    output logic                        instr_req_o,      // room for a word
    input  wire logic                   instr_ready_i,    // fetch has a word
    output logic                        valid_o
);

    fetch_item_t        item_q;
    logic [INT_BUS-1:0] int_flag_q;
    logic               valid_q;
    logic               en;
    logic               clear;

    assign instr_req_o = ~valid_q | ready_i;  // empty or draining
    assign en          = instr_req_o & instr_ready_i;
    // flush, or a bubble when no word shows up
    assign clear       = (hold_i == PIPE_CLEAR) | (instr_req_o & ~instr_ready_i);

    always_ff @(posedge clk_i) begin : valid_ctrl
        if (!rst_ni) valid_q <= 1'b0;
        else valid_q <= (en | (valid_q & ~ready_i)) & (hold_i != PIPE_CLEAR);  // held in stall
    end : valid_ctrl

    always_ff @(posedge clk_i) begin : stage_regs
        if (!rst_ni || clear) begin
            item_q     <= '{inst: INST_NOP, inst_addr: '0, inst_addr_next: '0};
            int_flag_q <= '0;
        end else if (en) begin
            item_q     <= item_i;
            int_flag_q <= int_flag_i;  // flags ride with the word
        end
    end : stage_regs

    assign inst_o           = item_q.inst;
    assign inst_addr_o      = item_q.inst_addr;
    assign inst_addr_next_o = item_q.inst_addr_next;
    assign int_flag_o       = int_flag_q;
    assign valid_o          = valid_q;

endmodule

`default_nettype wire

// ==== inst_rom.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction rom
// single port, one word per cycle, registered output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module inst_rom
    import tinyfe_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rd_en_i,    // read strobe
    input  wire logic [RomAw-1:0]   rd_addr_i,  // word index
    output logic      [InstBus-1:0] rd_data_o   // holds until next read
);

    logic [InstBus-1:0] mem [RomDepth];  // program image

    initial begin
        $readmemh("prog.hex", mem);
    end

    always_ff @(posedge clk_i) begin : rom_read
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];  // sync read
        end
    end : rom_read

endmodule

`default_nettype wire

// ==== load_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load port
// external four-phase load requests turned into rom
// reads through the arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module load_port
    import tinyfe_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   load_req_i,
    input  wire logic [InstAddrBus-1:0] load_addr_i,
    output logic                        load_ack_o,
    output logic      [InstBus-1:0]     load_data_o,
    output mem_req_t                    mem_req_o,
    input  wire mem_rsp_t               mem_rsp_i
);

    typedef enum logic [1:0] {
        LD_IDLE,  // wait for external req
        LD_READ,  // arbiter req up
        LD_ACK    // external ack up
    } ld_state_e;

    ld_state_e          state_q;
    logic [RomAw-1:0]   addr_q;  // latched word index
    logic [InstBus-1:0] data_q;  // latched load result

    always_ff @(posedge clk_i) begin : ld_fsm
        if (!rst_ni) begin
            state_q <= LD_IDLE;
        end else begin
            case (state_q)
                LD_IDLE: if (load_req_i & ~mem_rsp_i.ack) state_q <= LD_READ;
                LD_READ: if (mem_rsp_i.ack) state_q <= LD_ACK;
                LD_ACK:  if (!load_req_i) state_q <= LD_IDLE;
                default: state_q <= LD_IDLE;
            endcase
        end
    end : ld_fsm

    always_ff @(posedge clk_i) begin : ld_data
        if (state_q == LD_IDLE && load_req_i) addr_q <= load_addr_i[RomAw+1:2];
        if (state_q == LD_READ && mem_rsp_i.ack) data_q <= mem_rsp_i.data;
    end : ld_data

    assign mem_req_o   = '{req: (state_q == LD_READ), addr: addr_q};
    assign load_ack_o  = (state_q == LD_ACK);
    assign load_data_o = data_q;

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rom arbiter
// round robin between fetch unit and load port, each
// on a four-phase req/ack port, one read at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_arbiter
    import tinyfe_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire mem_req_t           fetch_req_i,
    input  wire mem_req_t           load_req_i,
    output mem_rsp_t                fetch_rsp_o,
    output mem_rsp_t                load_rsp_o,
    output logic                    rom_en_o,
    output logic      [RomAw-1:0]   rom_addr_o,
    input  wire logic [InstBus-1:0] rom_data_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,     // wait for a req
        ARB_READ,     // rom read of granted port
        ARB_ACK,      // ack up until req drops
        ARB_RELEASE   // ack down, one cycle gap
    } arb_state_e;

    arb_state_e state_q;
    logic       grant_q;    // last grant, 1 = load port
    logic       pick_load;  // idle choice
    logic       gnt_req;    // req of the granted port

    // tie goes to the port not served last
    assign pick_load = load_req_i.req & (~fetch_req_i.req | ~grant_q);
    assign gnt_req   = grant_q ? load_req_i.req : fetch_req_i.req;

    always_ff @(posedge clk_i) begin : arb_fsm
        if (!rst_ni) begin
            state_q <= ARB_IDLE;
            grant_q <= 1'b1;  // fetch wins the first tie
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (fetch_req_i.req | load_req_i.req) begin
                        grant_q <= pick_load;
                        state_q <= ARB_READ;
                    end
                end
                ARB_READ:    state_q <= ARB_ACK;  // data lands now
                ARB_ACK:     if (!gnt_req) state_q <= ARB_RELEASE;
                ARB_RELEASE: state_q <= ARB_IDLE;
                default:     state_q <= ARB_IDLE;
            endcase
        end
    end : arb_fsm

    assign rom_en_o   = (state_q == ARB_READ);
    assign rom_addr_o = grant_q ? load_req_i.addr : fetch_req_i.addr;

    // rom output holds between reads, so data is shared
    assign fetch_rsp_o = '{ack: (state_q == ARB_ACK) & ~grant_q, data: rom_data_i};
    assign load_rsp_o  = '{ack: (state_q == ARB_ACK) & grant_q, data: rom_data_i};

endmodule

`default_nettype wire

// ==== prog.hex ====
// one 32-bit instruction word per line, word index 0 to 15
00000093
00100113
00208193
00310213
00418293
00520313
00628393
00730413
00838493
00940513
00a48593
00b50613
00c58693
00d60713
00e68793
00f70813

// ==== tb_fetch_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end testbench
// directed tests for fetch order, stalls, redirect,
// loads under contention and interrupt flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_fetch_top
    import tinyfe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ItemTimeout    = 100;   // cycles to wait for one item
    localparam int WatchdogCycles = 5000;  // ~60 items and 6 loads, generous margin

    typedef struct packed {
        logic [InstBus-1:0]     inst;
        logic [InstAddrBus-1:0] addr;
        logic [InstAddrBus-1:0] next;
        logic [INT_BUS-1:0]     flag;
    } acc_t;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    hold_e                  hold_i;
    logic [InstAddrBus-1:0] jump_addr_i;
    logic [INT_BUS-1:0]     int_flag_i;
    logic                   ready_i;
    logic                   valid_o;
    logic [InstBus-1:0]     inst_o;
    logic [InstAddrBus-1:0] inst_addr_o;
    logic [InstAddrBus-1:0] inst_addr_next_o;
    logic [INT_BUS-1:0]     int_flag_o;
    logic                   load_req_i;
    logic [InstAddrBus-1:0] load_addr_i;
    logic                   load_ack_o;
    logic [InstBus-1:0]     load_data_o;

    logic [InstBus-1:0]     model [RomDepth];  // reference program image
    acc_t                   acc_q [$];         // items taken by decode
    logic [InstAddrBus-1:0] exp_addr;
    logic [INT_BUS-1:0]     exp_flag;
    int                     seed = 32'heb3a319f;
    int                     errors = 0;
    int                     checks = 0;

    fetch_top dut (.*);

    always #10 clk_i = ~clk_i;  // 20 ns period

    // sampled mid-cycle, item leaves at the next rising edge
    always @(negedge clk_i) begin : accept_monitor
        acc_t item;
        if (rst_ni && valid_o && ready_i) begin
            item.inst = inst_o;
            item.addr = inst_addr_o;
            item.next = inst_addr_next_o;
            item.flag = int_flag_o;
            acc_q.push_back(item);
        end
    end : accept_monitor

    initial begin : watchdog
        repeat (WatchdogCycles) @(posedge clk_i);
        $display("watchdog expired, the run did not finish in %0d cycles", WatchdogCycles);
        $display("TB FAILED");
        $finish;
    end : watchdog

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%s done, %0d errors", name, errors - err0);
    endtask

    // next item must continue the program order
    task automatic check_next_item();
        acc_t item;
        item = acc_q.pop_front();
        compare("inst_addr_o", item.addr, exp_addr);
        compare("inst_o", item.inst, model[exp_addr[RomAw+1:2]]);
        compare("inst_addr_next_o", item.next, exp_addr + 32'd4);
        compare("int_flag_o", {24'd0, item.flag}, {24'd0, exp_flag});
        exp_addr = exp_addr + 32'd4;
    endtask

    task automatic wait_items(input int n);
        int cycles;
        for (int i = 0; i < n; i++) begin
            cycles = 0;
            while (acc_q.size() == 0 && cycles < ItemTimeout) begin
                @(negedge clk_i);
                cycles++;
            end
            if (acc_q.size() == 0) begin
                $display("no instruction accepted within %0d cycles", ItemTimeout);
                errors++;
                return;
            end
            check_next_item();
        end
    endtask

    task automatic drain_items(output int n);
        n = 0;
        while (acc_q.size() > 0) begin
            check_next_item();
            n++;
        end
    endtask

    // one cycle of clear, flags change on the same edge
    task automatic redirect_to(input logic [31:0] addr, input logic [INT_BUS-1:0] flag);
        int n;
        @(posedge clk_i);
        hold_i      <= PIPE_CLEAR;
        jump_addr_i <= addr;
        int_flag_i  <= flag;
        @(posedge clk_i);
        hold_i <= HOLD_NONE;
        drain_items(n);  // taken before the flush
        exp_addr = addr;
        exp_flag = flag;
    endtask

    task automatic wait_load_ack(input logic level);
        int cycles;
        cycles = 0;
        while (load_ack_o !== level && cycles < ItemTimeout) begin
            @(negedge clk_i);
            cycles++;
        end
        if (load_ack_o !== level) begin
            $display("load ack did not go to %0d within %0d cycles", level, ItemTimeout);
            errors++;
        end
    endtask

    task automatic test_reset_sequence();
        int err0;
        err0 = errors;
        @(negedge clk_i);
        compare("valid_o", {31'd0, valid_o}, 32'd0);
        compare("inst_o", inst_o, INST_NOP);
        exp_addr = '0;
        exp_flag = '0;
        wait_items(8);
        report_test("reset and sequence", err0);
    endtask

    task automatic test_backpressure();
        int          err0;
        int          got;
        int          cycles;
        logic [31:0] rnd;
        err0   = errors;
        got    = 0;
        cycles = 0;
        while (got < 16 && cycles < 16 * ItemTimeout) begin
            @(posedge clk_i);
            rnd = $random(seed);
            ready_i <= rnd[0];
            cycles++;
            while (acc_q.size() > 0) begin
                check_next_item();
                got++;
            end
        end
        @(posedge clk_i);
        ready_i <= 1'b1;
        if (got < 16) begin
            $display("stream stopped under back-pressure after %0d items", got);
            errors++;
        end
        report_test("back-pressure", err0);
    endtask

    task automatic test_redirect();
        int err0;
        err0 = errors;
        redirect_to(32'h20, exp_flag);
        wait_items(6);
        report_test("redirect", err0);
    endtask

    task automatic test_loads();
        int          err0;
        int          n;
        int          fetched;
        logic [31:0] rnd;
        logic [31:0] addr;
        err0    = errors;
        fetched = 0;
        for (int i = 0; i < 6; i++) begin
            rnd  = $random(seed);
            addr = rnd & 32'h0000_00fc;  // upper bits wrap in the rom
            @(posedge clk_i);
            load_req_i  <= 1'b1;
            load_addr_i <= addr;
            wait_load_ack(1'b1);
            compare("load_data_o", load_data_o, model[addr[RomAw+1:2]]);
            @(posedge clk_i);
            load_req_i <= 1'b0;
            wait_load_ack(1'b0);
            repeat (rnd[9:8]) @(posedge clk_i);
            drain_items(n);
            fetched += n;
        end
        if (fetched == 0) begin
            $display("fetch made no progress while loads ran");
            errors++;
        end
        report_test("loads under contention", err0);
    endtask

    task automatic test_int_flags();
        int err0;
        err0 = errors;
        redirect_to(32'h0, 8'h5a);
        wait_items(5);
        redirect_to(32'h10, 8'ha5);
        wait_items(5);
        report_test("interrupt flags", err0);
    endtask

    initial begin : main
        $readmemh("prog.hex", model);
        rst_ni      <= 1'b0;
        hold_i      <= HOLD_NONE;
        jump_addr_i <= '0;
        int_flag_i  <= '0;
        ready_i     <= 1'b1;
        load_req_i  <= 1'b0;
        load_addr_i <= '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        test_reset_sequence();
        test_backpressure();
        test_redirect();
        test_loads();
        test_int_flags();
        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end : main

endmodule

`default_nettype wire

// ==== tinyfe_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tinyfe shared definitions
// bus widths, rom size, nop encoding, hold codes and
// the structs passed between the front end blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tinyfe_pkg;

    localparam int InstBus     = 32;                 // instruction word width
    localparam int InstAddrBus = 32;                 // byte address width
    localparam int INT_BUS     = 8;                  // interrupt flag vector
    localparam int RomDepth    = 16;                 // words in the rom
    localparam int RomAw       = $clog2(RomDepth);   // word index width

    localparam logic [InstBus-1:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    // hold bus from the rest of the pipeline
    typedef enum logic [1:0] {
        HOLD_NONE  = 2'd0,  // run
        HOLD_FETCH = 2'd1,  // no new fetch reads
        PIPE_CLEAR = 2'd2   // flush if_id, redirect pc
    } hold_e;

    // requester to arbiter
    typedef struct packed {
        logic             req;   // four-phase request
        logic [RomAw-1:0] addr;  // word index
    } mem_req_t;

    // arbiter to requester
    typedef struct packed {
        logic               ack;   // four-phase acknowledge
        logic [InstBus-1:0] data;  // rom word, valid with ack
    } mem_rsp_t;

    // fetch unit to if_id
    typedef struct packed {
        logic [InstBus-1:0]     inst;            // instruction word
        logic [InstAddrBus-1:0] inst_addr;       // its byte address
        logic [InstAddrBus-1:0] inst_addr_next;  // address + 4
    } fetch_item_t;

endpackage

`default_nettype wire
